/* design/mdio_pkg.sv */
package mdio_pkg;

  // --------------------
  // field widths
  // --------------------

  // clause-22 phy address
  typedef logic [4:0] phy_addr_t;
  // register number inside one phy
  typedef logic [4:0] reg_addr_t;
  // one phy register value
  typedef logic [15:0] mdio_data_t;
  // wishbone word offset, four registers
  typedef logic [1:0] wb_addr_t;
  typedef logic [31:0] wb_data_t;

  // --------------------
  // register map
  // --------------------
  localparam wb_addr_t REG_ADDR   = 2'd0;
  localparam wb_addr_t REG_WDATA  = 2'd1;
  localparam wb_addr_t REG_CMD    = 2'd2;
  localparam wb_addr_t REG_STATUS = 2'd3;

  // --------------------
  // frame timing
  // --------------------

  // clocks per mdc half period, one mdc bit is 2*MDC_HALF clocks
  localparam int MDC_HALF   = 4;
  localparam int MDC_CNT_W  = $clog2(MDC_HALF);
  // preamble, st, op, phyad, regad, ta and data
  localparam int FRAME_BITS = 64;
  // index of the last regad bit, the line is let go below it on a read
  localparam int TA_BIT     = 18;

  // mdc half-period divider count
  typedef logic [MDC_CNT_W-1:0] mdc_cnt_t;
  // frame bit index, one extra bit so FRAME_BITS itself means "before bit 63"
  typedef logic [$clog2(FRAME_BITS):0] bit_idx_t;

  // command handed from the register block to the engine
  typedef struct packed {
    logic       write;
    phy_addr_t  phy;
    reg_addr_t  reg_addr;
    mdio_data_t wdata;
  } mdio_cmd_t;

  // value and enable for the mdio pin
  typedef struct packed {
    logic out;
    logic oe;
  } mdio_bit_t;

  typedef enum logic [1:0] {
    ENG_IDLE,
    ENG_SHIFT,
    ENG_DONE
  } engine_state_t;

endpackage

/* design/mdio_wb_regs.sv */
`timescale 1ns/1ns

module mdio_wb_regs (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  cyc,
  input  logic                  stb,
  input  logic                  we,
  input  mdio_pkg::wb_addr_t    adr,
  input  mdio_pkg::wb_data_t    dat_w,
  input  logic                  done,
  input  mdio_pkg::mdio_data_t  rdata,
  output mdio_pkg::wb_data_t    dat_r,
  output logic                  ack,
  output logic                  start,
  output mdio_pkg::mdio_cmd_t   cmd
);

  logic                 access;
  logic                 wr_en;
  logic                 cmd_accept;
  logic                 busy;
  mdio_pkg::phy_addr_t  phy_q;
  mdio_pkg::reg_addr_t  reg_q;
  mdio_pkg::mdio_data_t wdata_q;
  mdio_pkg::mdio_data_t rdata_q;
  mdio_pkg::wb_data_t   rd_mux;

  // --------------------
  // bus handshake
  // --------------------

  // new cycle seen while ack is still low
  assign access = cyc && stb && !ack;
  assign wr_en  = access && we;

  // cmd write with at least one start bit, dropped while a frame runs
  assign cmd_accept = wr_en && (adr == mdio_pkg::REG_CMD) && !busy
                      && (dat_w[0] || dat_w[1]);

  // single-cycle ack, no wait states
  always_ff @(posedge clock)
  begin
    if (reset)
      ack <= 1'b0;
    else
      ack <= access;
  end

  // readback mux
  always_comb
  begin
    rd_mux = '0;
    case (adr)
      mdio_pkg::REG_ADDR:   rd_mux[9:0]  = {phy_q, reg_q};
      mdio_pkg::REG_WDATA:  rd_mux[15:0] = wdata_q;
      // busy flag sits above the last read value
      mdio_pkg::REG_STATUS: rd_mux[16:0] = {busy, rdata_q};
      // cmd reads as zero
      default:              rd_mux = '0;
    endcase
  end

  // read data is held while ack is high
  always_ff @(posedge clock)
  begin
    if (access && !we)
      dat_r <= rd_mux;
  end

  // --------------------
  // address and data regs
  // --------------------
  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      phy_q   <= '0;
      reg_q   <= '0;
      wdata_q <= '0;
    end
    else if (wr_en)
    begin
      if (adr == mdio_pkg::REG_ADDR)
      begin
        phy_q <= dat_w[9:5];
        reg_q <= dat_w[4:0];
      end
      if (adr == mdio_pkg::REG_WDATA)
        wdata_q <= dat_w[15:0];
    end
  end

  // --------------------
  // command issue
  // --------------------

  // busy from accept until the engine reports done
  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      start   <= 1'b0;
      busy    <= 1'b0;
      rdata_q <= '0;
    end
    else
    begin
      start <= cmd_accept;
      if (cmd_accept)
        busy <= 1'b1;
      else if (done)
        busy <= 1'b0;
      // only reads update the status value
      if (done && !cmd.write)
        rdata_q <= rdata;
    end
  end

  // snapshot of the fields, stays put for the whole frame
  always_ff @(posedge clock)
  begin
    if (cmd_accept)
    begin
      // bit 0 means read and wins over bit 1
      cmd.write    <= !dat_w[0];
      cmd.phy      <= phy_q;
      cmd.reg_addr <= reg_q;
      cmd.wdata    <= wdata_q;
    end
  end

  a_ack_one_cycle: assert property (@(posedge clock) disable iff (reset)
    ack |=> !ack)
    else $error("wishbone ack held for more than one cycle");

  // the engine only reports completion of a frame this block started
  a_done_while_busy: assert property (@(posedge clock) disable iff (reset)
    done |-> busy)
    else $error("done seen with no command outstanding");

endmodule

/* design/mdio_frame_engine.sv */
`timescale 1ns/1ns

module mdio_frame_engine (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  start,
  input  mdio_pkg::mdio_cmd_t   cmd,
  input  logic                  bit_tick,
  input  logic                  sample_tick,
  input  logic                  in_bit,
  output mdio_pkg::mdio_bit_t   line,
  output logic                  done,
  output mdio_pkg::mdio_data_t  rdata
);

  mdio_pkg::engine_state_t         state;
  mdio_pkg::bit_idx_t              idx;
  logic [mdio_pkg::FRAME_BITS-1:0] frame;
  logic [mdio_pkg::FRAME_BITS-1:0] next_frame;
  logic [1:0]                      op;
  logic                            is_read;
  logic                            sample_q;
  logic                            waiting;
  mdio_pkg::mdio_data_t            shift_in;

  // --------------------
  // frame build
  // --------------------

  // opcode 10 read, 01 write
  assign op = cmd.write ? 2'b01 : 2'b10;

  // 32 preamble ones, st 01, op, phyad, regad, ta, data
  // on a read the ta and data slots are ones, the line is let go there anyway
  assign next_frame = {32'hFFFF_FFFF, 2'b01, op, cmd.phy, cmd.reg_addr,
                       cmd.write ? 2'b10 : 2'b11,
                       cmd.write ? cmd.wdata : 16'hFFFF};

  always_ff @(posedge clock)
  begin
    if (state == mdio_pkg::ENG_IDLE && start)
      frame <= next_frame;
  end

  // --------------------
  // bit sequencer
  // --------------------

  // idx == FRAME_BITS holds the line until the first mdc fall
  assign waiting = (idx == mdio_pkg::bit_idx_t'(mdio_pkg::FRAME_BITS));

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      state   <= mdio_pkg::ENG_IDLE;
      idx     <= '0;
      is_read <= 1'b0;
    end
    else
    begin
      case (state)
        mdio_pkg::ENG_IDLE:
          if (start)
          begin
            state   <= mdio_pkg::ENG_SHIFT;
            idx     <= mdio_pkg::bit_idx_t'(mdio_pkg::FRAME_BITS);
            is_read <= !cmd.write;
          end
        mdio_pkg::ENG_SHIFT:
          // one bit per mdc fall, the fall after bit 0 ends the frame
          if (bit_tick)
          begin
            if (idx == '0)
              state <= mdio_pkg::ENG_DONE;
            else
              idx <= idx - mdio_pkg::bit_idx_t'(1);
          end
        mdio_pkg::ENG_DONE:
          state <= mdio_pkg::ENG_IDLE;
        default:
          state <= mdio_pkg::ENG_IDLE;
      endcase
    end
  end

  // done is the single ENG_DONE cycle
  assign done = (state == mdio_pkg::ENG_DONE);

  // --------------------
  // pin value
  // --------------------
  always_comb
  begin
    // idle line is released, pull-up keeps it high
    line.out = 1'b1;
    line.oe  = 1'b0;
    if (state == mdio_pkg::ENG_SHIFT && !waiting)
    begin
      line.out = frame[idx[$clog2(mdio_pkg::FRAME_BITS)-1:0]];
      // read frames let go once past the last regad bit
      line.oe  = !(is_read && idx < mdio_pkg::bit_idx_t'(mdio_pkg::TA_BIT));
    end
  end

  // --------------------
  // read capture
  // --------------------

  // in_bit is registered on sample_tick, use it one clock later
  always_ff @(posedge clock)
  begin
    if (reset)
      sample_q <= 1'b0;
    else
      sample_q <= sample_tick;
  end

  // msb first, the rises inside data bits 15..0
  always_ff @(posedge clock)
  begin
    if (state == mdio_pkg::ENG_SHIFT && is_read && sample_q
        && idx < mdio_pkg::bit_idx_t'($bits(mdio_pkg::mdio_data_t)))
      shift_in <= {shift_in[14:0], in_bit};
  end

  assign rdata = shift_in;

  a_idle_released: assert property (@(posedge clock) disable iff (reset)
    state == mdio_pkg::ENG_IDLE |-> !line.oe)
    else $error("mdio driven while the engine is idle");

  // the register block must hold off new commands until done
  a_start_in_idle: assert property (@(posedge clock) disable iff (reset)
    start |-> state == mdio_pkg::ENG_IDLE)
    else $error("start received while a frame is in progress");

endmodule

/* design/mdio_pin_driver.sv */
`timescale 1ns/1ns

module mdio_pin_driver (
  input  logic                clock,
  input  logic                reset,
  input  mdio_pkg::mdio_bit_t line,
  input  logic                mdio_in,
  output logic                mdc,
  output logic                mdio_out,
  output logic                mdio_oe,
  output logic                bit_tick,
  output logic                sample_tick,
  output logic                in_bit
);

  mdio_pkg::mdc_cnt_t div_cnt;
  logic               half_end;

  // --------------------
  // mdc divider
  // --------------------

  // last clock of an mdc half period
  assign half_end = (div_cnt == mdio_pkg::mdc_cnt_t'(mdio_pkg::MDC_HALF - 1));

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      div_cnt <= '0;
      mdc     <= 1'b0;
    end
    else
    begin
      div_cnt <= half_end ? '0 : div_cnt + mdio_pkg::mdc_cnt_t'(1);
      if (half_end)
        mdc <= !mdc;
    end
  end

  // mdc falls on the edge ending a bit_tick cycle, rises after a sample_tick
  assign bit_tick    = half_end && mdc;
  assign sample_tick = half_end && !mdc;

  // --------------------
  // pin registers
  // --------------------
  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      mdio_out <= 1'b1;
      mdio_oe  <= 1'b0;
    end
    else
    begin
      mdio_out <= line.out;
      mdio_oe  <= line.oe;
    end
  end

  // capture on the same edge as the mdc rise
  always_ff @(posedge clock)
  begin
    if (sample_tick)
      in_bit <= mdio_in;
  end

  a_mdc_on_tick: assert property (@(posedge clock) disable iff (reset)
    $changed(mdc) |-> $past(bit_tick || sample_tick))
    else $error("mdc toggled without a tick");

endmodule

/* design/mdio_master.sv */
`timescale 1ns/1ns

module mdio_master (
  input  logic               clock,
  input  logic               reset,
  // wishbone classic slave
  input  logic               cyc,
  input  logic               stb,
  input  logic               we,
  input  mdio_pkg::wb_addr_t adr,
  input  mdio_pkg::wb_data_t dat_w,
  output mdio_pkg::wb_data_t dat_r,
  output logic               ack,
  // mdio pins, tristate buffer lives on the board
  input  logic               mdio_in,
  output logic               mdc,
  output logic               mdio_out,
  output logic               mdio_oe
);

  // --------------------
  // internal links
  // --------------------

  // register block to engine
  logic                 start;
  mdio_pkg::mdio_cmd_t  cmd;
  logic                 done;
  mdio_pkg::mdio_data_t rdata;

  // engine to pin driver
  mdio_pkg::mdio_bit_t  line;
  logic                 bit_tick;
  logic                 sample_tick;
  logic                 in_bit;

  // host side
  mdio_wb_regs i_mdio_wb_regs (
    .clock (clock),
    .reset (reset),
    .cyc   (cyc),
    .stb   (stb),
    .we    (we),
    .adr   (adr),
    .dat_w (dat_w),
    .done  (done),
    .rdata (rdata),
    .dat_r (dat_r),
    .ack   (ack),
    .start (start),
    .cmd   (cmd)
  );

  // clause-22 framing
  mdio_frame_engine i_mdio_frame_engine (
    .clock       (clock),
    .reset       (reset),
    .start       (start),
    .cmd         (cmd),
    .bit_tick    (bit_tick),
    .sample_tick (sample_tick),
    .in_bit      (in_bit),
    .line        (line),
    .done        (done),
    .rdata       (rdata)
  );

  // mdc and pin timing
  mdio_pin_driver i_mdio_pin_driver (
    .clock       (clock),
    .reset       (reset),
    .line        (line),
    .mdio_in     (mdio_in),
    .mdc         (mdc),
    .mdio_out    (mdio_out),
    .mdio_oe     (mdio_oe),
    .bit_tick    (bit_tick),
    .sample_tick (sample_tick),
    .in_bit      (in_bit)
  );

endmodule

/* bench/mdio_phy_model.sv */
`timescale 1ns/1ns

module mdio_phy_model (
  input  logic clock,
  input  logic reset,
  input  logic mdc,
  input  logic mdio_out,
  input  logic mdio_oe,
  output logic phy_out,
  output logic phy_oe,
  output logic frame_error,
  output int   frame_count
);

  // the only address this phy answers to
  localparam logic [4:0] PHY_ADDR = 5'd7;

  logic        mdc_q;
  logic        rise;
  logic        active;
  logic [5:0]  bit_idx;
  // preamble through regad, 46 bits
  logic [45:0] header;
  logic [15:0] data_sr;
  logic [15:0] regs [32];
  logic [15:0] rd_word;
  logic [3:0]  rd_pos;
  logic        header_ok;
  logic        is_read;
  logic        selected;
  logic [4:0]  reg_sel;

  // mdc rise seen one clock late, the line is long settled by then
  assign rise = mdc && !mdc_q;

  // --------------------
  // header decode
  // --------------------
  assign header_ok = (header[45:14] == '1) && (header[13:12] == 2'b01)
                     && (header[11] != header[10]);
  assign is_read   = (header[11:10] == 2'b10);
  assign selected  = (header[9:5] == PHY_ADDR);
  assign reg_sel   = header[4:0];
  assign rd_word   = regs[reg_sel];
  // data bit driven after the rise of bit k is bit k-1
  assign rd_pos    = 4'(bit_idx - 6'd1);

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      mdc_q       <= 1'b0;
      active      <= 1'b0;
      bit_idx     <= '0;
      phy_out     <= 1'b1;
      phy_oe      <= 1'b0;
      frame_error <= 1'b0;
      frame_count <= 0;
      for (int i = 0; i < 32; i++)
        regs[i] <= {3'b110, i[4:0], 3'b011, i[4:0]};
    end
    else
    begin
      mdc_q <= mdc;
      if (rise && !active)
      begin
        // first driven bit is preamble bit 63
        if (mdio_oe)
        begin
          active  <= 1'b1;
          bit_idx <= 6'd62;
          header  <= {45'd0, mdio_out};
        end
      end
      else if (rise && bit_idx >= 6'd18)
      begin
        // master must drive every header bit
        if (!mdio_oe)
          frame_error <= 1'b1;
        header  <= {header[44:0], mdio_out};
        bit_idx <= bit_idx - 6'd1;
      end
      else if (rise)
      begin
        // from the turnaround on the opcode decides who drives
        if (mdio_oe == is_read)
          frame_error <= 1'b1;
        if (bit_idx == 6'd17 && !header_ok)
          frame_error <= 1'b1;
        if (!is_read && bit_idx < 6'd16)
          data_sr <= {data_sr[14:0], mdio_out};
        if (is_read && selected)
        begin
          phy_oe <= (bit_idx != 6'd0);
          // second ta bit is a zero
          if (bit_idx == 6'd17)
            phy_out <= 1'b0;
          else if (bit_idx == 6'd0)
            phy_out <= 1'b1;
          else
            phy_out <= rd_word[rd_pos];
        end
        if (bit_idx == 6'd0)
        begin
          active      <= 1'b0;
          frame_count <= frame_count + 1;
          if (!is_read && selected)
            regs[reg_sel] <= {data_sr[14:0], mdio_out};
        end
        else
          bit_idx <= bit_idx - 6'd1;
      end
    end
  end

endmodule

/* bench/mdio_master_tb.sv */
`timescale 1ns/1ns

module mdio_master_tb;

  // same address as the phy model
  localparam mdio_pkg::phy_addr_t PHY_ADDR   = 5'd7;
  localparam int                  ACK_LIMIT  = 16;
  localparam int                  POLL_LIMIT = 400;

  typedef enum logic [1:0] {
    OP_WRITE,
    OP_READ,
    // write, then a second cmd while that frame still runs
    OP_WRITE_BUSY
  } op_t;

  typedef struct packed {
    op_t                  op;
    mdio_pkg::phy_addr_t  phy;
    mdio_pkg::reg_addr_t  regno;
    mdio_pkg::mdio_data_t data;
  } entry_t;

  logic               clock;
  logic               reset;
  logic               cyc;
  logic               stb;
  logic               we;
  mdio_pkg::wb_addr_t adr;
  mdio_pkg::wb_data_t dat_w;
  mdio_pkg::wb_data_t dat_r;
  logic               ack;
  logic               mdc;
  logic               mdio_out;
  logic               mdio_oe;
  logic               mdio_in;
  logic               phy_out;
  logic               phy_oe;
  logic               frame_error;
  int                 frame_count;

  entry_t             table_q[$];
  logic [31:0]        rng_state;
  logic               timed_out;
  int                 errors;
  int                 test_errors;
  int                 tests_run;
  int                 tests_failed;
  int                 accepted;

  always #10 clock = ~clock;

  // open-drain line with the board pull-up
  assign mdio_in = phy_oe ? phy_out : (mdio_oe ? mdio_out : 1'b1);

  mdio_master i_mdio_master (
    .clock    (clock),
    .reset    (reset),
    .cyc      (cyc),
    .stb      (stb),
    .we       (we),
    .adr      (adr),
    .dat_w    (dat_w),
    .dat_r    (dat_r),
    .ack      (ack),
    .mdio_in  (mdio_in),
    .mdc      (mdc),
    .mdio_out (mdio_out),
    .mdio_oe  (mdio_oe)
  );

  mdio_phy_model i_phy_model (
    .clock       (clock),
    .reset       (reset),
    .mdc         (mdc),
    .mdio_out    (mdio_out),
    .mdio_oe     (mdio_oe),
    .phy_out     (phy_out),
    .phy_oe      (phy_oe),
    .frame_error (frame_error),
    .frame_count (frame_count)
  );

  // --------------------
  // helpers
  // --------------------

  // xorshift32
  function automatic mdio_pkg::mdio_data_t next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state[15:0];
  endfunction

  function automatic entry_t make_entry(input op_t op, input mdio_pkg::phy_addr_t phy,
                                        input mdio_pkg::reg_addr_t regno,
                                        input mdio_pkg::mdio_data_t data);
    entry_t e;
    e.op    = op;
    e.phy   = phy;
    e.regno = regno;
    e.data  = data;
    return e;
  endfunction

  function automatic string op_label(input op_t op);
    case (op)
      OP_WRITE: return "write";
      OP_READ:  return "read";
      default:  return "write while busy";
    endcase
  endfunction

  task automatic report_mismatch(input string what, input mdio_pkg::wb_data_t got,
                                 input mdio_pkg::wb_data_t want);
    $display("CHECK FAILED at %0t ns: %s, read %h, expected %h", $time, what, got, want);
    errors      = errors + 1;
    test_errors = test_errors + 1;
  endtask

  task automatic finish_test(input string name);
    tests_run = tests_run + 1;
    if (test_errors == 0)
      $display("test %0d %s: ok", tests_run, name);
    else
    begin
      tests_failed = tests_failed + 1;
      $display("test %0d %s: %0d errors", tests_run, name, test_errors);
    end
    test_errors = 0;
  endtask

  // one classic cycle, inputs driven at the rising edge, ack sampled mid-cycle
  task automatic wb_cycle(input logic write, input mdio_pkg::wb_addr_t addr,
                          input mdio_pkg::wb_data_t wdata,
                          output mdio_pkg::wb_data_t rdata);
    int waited;
    waited = 0;
    rdata  = '0;
    if (!timed_out)
    begin
      @(posedge clock);
      cyc   <= 1'b1;
      stb   <= 1'b1;
      we    <= write;
      adr   <= addr;
      dat_w <= wdata;
      @(negedge clock);
      while (!ack && waited < ACK_LIMIT)
      begin
        @(negedge clock);
        waited = waited + 1;
      end
      if (ack)
        rdata = dat_r;
      else
      begin
        $display("no ack from the Wishbone slave within %0d cycles at %0t ns",
                 ACK_LIMIT, $time);
        timed_out   = 1'b1;
        errors      = errors + 1;
        test_errors = test_errors + 1;
      end
      @(posedge clock);
      cyc <= 1'b0;
      stb <= 1'b0;
      we  <= 1'b0;
    end
  endtask

  task automatic write_reg(input mdio_pkg::wb_addr_t addr, input mdio_pkg::wb_data_t data);
    mdio_pkg::wb_data_t unused;
    wb_cycle(1'b1, addr, data, unused);
  endtask

  task automatic read_reg(input mdio_pkg::wb_addr_t addr, output mdio_pkg::wb_data_t data);
    wb_cycle(1'b0, addr, '0, data);
  endtask

  // poll the busy bit until the frame is over
  task automatic wait_idle();
    mdio_pkg::wb_data_t status;
    int                 polls;
    polls = 0;
    read_reg(mdio_pkg::REG_STATUS, status);
    while (status[16] && polls < POLL_LIMIT && !timed_out)
    begin
      read_reg(mdio_pkg::REG_STATUS, status);
      polls = polls + 1;
    end
    if (status[16] && !timed_out)
    begin
      $display("busy still set after %0d status polls at %0t ns", POLL_LIMIT, $time);
      timed_out   = 1'b1;
      errors      = errors + 1;
      test_errors = test_errors + 1;
    end
  endtask

  // --------------------
  // stimulus table
  // --------------------
  task automatic fill_table();
    mdio_pkg::reg_addr_t  regnos[4];
    mdio_pkg::mdio_data_t vals[4];
    mdio_pkg::mdio_data_t d;
    int                   i;
    regnos = '{5'd3, 5'd9, 5'd17, 5'd30};
    for (i = 0; i < 4; i++)
    begin
      vals[i] = next_rand();
      table_q.push_back(make_entry(OP_WRITE, PHY_ADDR, regnos[i], vals[i]));
    end
    // read back in the same order
    for (i = 0; i < 4; i++)
      table_q.push_back(make_entry(OP_READ, PHY_ADDR, regnos[i], vals[i]));
    // nobody at phy 12 so the pull-up wins
    table_q.push_back(make_entry(OP_READ, 5'd12, 5'd2, 16'hFFFF));
    d = next_rand();
    table_q.push_back(make_entry(OP_WRITE_BUSY, PHY_ADDR, 5'd21, d));
    table_q.push_back(make_entry(OP_READ, PHY_ADDR, 5'd21, d));
  endtask

  task automatic apply_entry(input entry_t e);
    mdio_pkg::wb_data_t q;
    write_reg(mdio_pkg::REG_ADDR, {22'd0, e.phy, e.regno});
    if (e.op == OP_READ)
      write_reg(mdio_pkg::REG_CMD, 32'h1);
    else
    begin
      write_reg(mdio_pkg::REG_WDATA, {16'd0, e.data});
      write_reg(mdio_pkg::REG_CMD, 32'h2);
    end
    accepted = accepted + 1;
    if (e.op == OP_WRITE_BUSY)
    begin
      // the frame has hundreds of clocks left
      read_reg(mdio_pkg::REG_STATUS, q);
      if (q[16] !== 1'b1)
        report_mismatch("busy bit during a frame", {31'd0, q[16]}, 32'd1);
      write_reg(mdio_pkg::REG_WDATA, {16'd0, ~e.data});
      write_reg(mdio_pkg::REG_CMD, 32'h2);
    end
    wait_idle();
    if (e.op == OP_READ)
    begin
      read_reg(mdio_pkg::REG_STATUS, q);
      if (q !== {16'd0, e.data})
        report_mismatch("STATUS after read", q, {16'd0, e.data});
    end
  endtask

  // --------------------
  // main sequence
  // --------------------
  initial
  begin
    mdio_pkg::wb_data_t q;
    int                 i;
    clock        = 1'b0;
    reset        = 1'b1;
    cyc          = 1'b0;
    stb          = 1'b0;
    we           = 1'b0;
    adr          = '0;
    dat_w        = '0;
    rng_state    = 32'd51;
    timed_out    = 1'b0;
    errors       = 0;
    test_errors  = 0;
    tests_run    = 0;
    tests_failed = 0;
    accepted     = 0;
    fill_table();

    repeat (4) @(posedge clock);
    reset <= 1'b0;

    // idle pins and status right out of reset
    @(negedge clock);
    if (mdc !== 1'b0)
      report_mismatch("mdc after reset", {31'd0, mdc}, 32'd0);
    if (mdio_oe !== 1'b0)
      report_mismatch("mdio_oe after reset", {31'd0, mdio_oe}, 32'd0);
    // released line idles high
    if (mdio_out !== 1'b1)
      report_mismatch("mdio_out after reset", {31'd0, mdio_out}, 32'd1);
    read_reg(mdio_pkg::REG_STATUS, q);
    if (q[16] !== 1'b0)
      report_mismatch("busy after reset", {31'd0, q[16]}, 32'd0);
    finish_test("reset state");

    // ADDR keeps 10 bits and WDATA 16, phy field in 9:5 and reg field in 4:0
    write_reg(mdio_pkg::REG_ADDR, 32'hA5A5_A5A5);
    read_reg(mdio_pkg::REG_ADDR, q);
    if (q !== 32'h0000_01A5)
      report_mismatch("ADDR readback", q, 32'h0000_01A5);
    write_reg(mdio_pkg::REG_WDATA, 32'h5A5A_C3C3);
    read_reg(mdio_pkg::REG_WDATA, q);
    if (q !== 32'h0000_C3C3)
      report_mismatch("WDATA readback", q, 32'h0000_C3C3);
    read_reg(mdio_pkg::REG_CMD, q);
    if (q !== 32'd0)
      report_mismatch("CMD readback", q, 32'd0);
    finish_test("register readback");

    for (i = 0; i < table_q.size() && !timed_out; i++)
    begin
      apply_entry(table_q[i]);
      finish_test($sformatf("%s phy %0d reg %0d", op_label(table_q[i].op),
                            table_q[i].phy, table_q[i].regno));
    end

    // whole-run bookkeeping in the phy model
    if (frame_error !== 1'b0)
      report_mismatch("phy model frame error", {31'd0, frame_error}, 32'd0);
    if (frame_count != accepted)
      report_mismatch("frames seen by the phy model", frame_count, accepted);
    finish_test("phy model totals");

    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0 && !timed_out)
      $display("RESULT: PASS");
    else
      $display("RESULT: FAIL");
    $finish;
  end

endmodule

/* verilog.f */
design/mdio_pkg.sv
design/mdio_wb_regs.sv
design/mdio_frame_engine.sv
design/mdio_pin_driver.sv
design/mdio_master.sv
bench/mdio_phy_model.sv
bench/mdio_master_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ns \
  --top-module mdio_master_tb -f verilog.f -o mdio_master_sim
./obj_dir/mdio_master_sim | tee sim.log

if grep -q "RESULT: FAIL" sim.log; then
  exit 1
fi
